/* hdl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath word width
`define CPU_XLEN 32

// Word program counter, 128 instructions
`define CPU_PC_W 7

// Data memory word address, 64 words
`define CPU_DMEM_AW 6

// Register specifier width, 32 registers
`define CPU_REG_AW 5

`endif

/* hdl/isa_pkg.sv */
`default_nettype none
`include "cpu_defines.svh"

package isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00, // All register-register ALU ops
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_SLT = 6'h2a // Signed compare
	} funct_t;

	typedef struct packed {
		opcode_t                op;
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] rd;
		logic [4:0]             shamt; // No shifts in this subset
		funct_t                 funct;
	} instr_r_t;

	typedef struct packed {
		opcode_t                op;
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [15:0]            imm16; // Sign extended in ID
	} instr_i_t;

	// Same 32-bit word, R view and I view
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

`default_nettype wire

/* hdl/pipe_pkg.sv */
`default_nettype none
`include "cpu_defines.svh"

package pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1, // Also the beq compare
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_t;

	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg; // Load data to WB
		logic    mem_read;
		logic    mem_write;
		logic    branch;
		logic    alu_src;    // Immediate as operand B
		logic    reg_dst;    // rd, else rt
		alu_op_t alu_op;
	} ctrl_t;

	//////////////////////////////
	// Stage registers

	typedef struct packed {
		logic                 valid;
		logic [`CPU_PC_W-1:0] pc_next;
		logic [`CPU_XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic                   valid;
		ctrl_t                  ctrl;
		logic [`CPU_PC_W-1:0]   pc_next;
		logic [`CPU_XLEN-1:0]   data1;
		logic [`CPU_XLEN-1:0]   data2;
		logic [`CPU_XLEN-1:0]   imm;
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] dst_r;
	} id_ex_t;

	typedef struct packed {
		logic                   valid;
		ctrl_t                  ctrl;
		logic [`CPU_PC_W-1:0]   branch_pc;
		logic                   zero;
		logic [`CPU_XLEN-1:0]   alu_result; // Also the data address
		logic [`CPU_XLEN-1:0]   store_data;
		logic [`CPU_REG_AW-1:0] dst;
	} ex_mem_t;

	typedef struct packed {
		logic                   valid;
		logic                   reg_write;
		logic [`CPU_REG_AW-1:0] dst;
		logic [`CPU_XLEN-1:0]   data;
	} wb_t;

	//////////////////////////////
	// Side ports

	typedef struct packed {
		logic                    en;
		logic [`CPU_DMEM_AW-1:0] addr;
		logic [`CPU_XLEN-1:0]    data;
	} dmem_wr_t;

	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1, // From EX/MEM
		FWD_WB   = 2'd2  // From MEM/WB
	} fwd_sel_t;

	typedef struct packed {
		logic                 we;
		logic [`CPU_PC_W-1:0] addr;
		logic [`CPU_XLEN-1:0] data;
	} imem_load_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module fetch_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enable,
	input  logic                 stall,
	input  logic                 branch_taken,
	input  logic [`CPU_PC_W-1:0] branch_pc,
	input  pipe_pkg::imem_load_t imem_load,
	output pipe_pkg::if_id_t     if_id
);

	logic [`CPU_XLEN-1:0] imem [0:(1<<`CPU_PC_W)-1]; // Instruction store
	logic [`CPU_PC_W-1:0] pc;
	logic [`CPU_PC_W-1:0] pc_inc;

	assign pc_inc = pc + 1'b1; // Wraps at the top of imem

	always_ff @(posedge clk) begin
		if (imem_load.we) begin
			imem[imem_load.addr] <= imem_load.data; // Loader port
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			if_id.valid <= 1'b0;
		end else if (enable) begin
			if (branch_taken) begin
				pc          <= branch_pc; // Redirect from MEM
				if_id.valid <= 1'b0;      // Squash wrong path
			end else if (!stall) begin
				pc            <= pc_inc;
				if_id.valid   <= 1'b1;
				if_id.pc_next <= pc_inc;
				if_id.instr   <= imem[pc]; // Async read
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module decode_stage (
	input  logic             clk,
	input  logic             rst,
	input  logic             enable,
	input  logic             stall,
	input  logic             flush,
	input  pipe_pkg::if_id_t if_id,
	input  pipe_pkg::wb_t    mem_wb,
	output pipe_pkg::id_ex_t id_ex
);

	isa_pkg::instr_u        iw;
	pipe_pkg::ctrl_t        ctrl_d;
	logic [`CPU_XLEN-1:0]   regs [0:(1<<`CPU_REG_AW)-1];
	logic                   wr_en;
	logic [`CPU_XLEN-1:0]   data1_d;
	logic [`CPU_XLEN-1:0]   data2_d;
	logic [`CPU_XLEN-1:0]   imm_d;
	logic [`CPU_REG_AW-1:0] dst_d;

	assign iw    = if_id.instr;
	assign wr_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.dst != '0);
	assign imm_d = {{(`CPU_XLEN-16){iw.i.imm16[15]}}, iw.i.imm16};
	assign dst_d = ctrl_d.reg_dst ? iw.r.rd : iw.r.rt;

	// r0 reads zero, WB write seen same cycle
	function automatic logic [`CPU_XLEN-1:0] read_reg(input logic [`CPU_REG_AW-1:0] idx);
		if (idx == '0)
			return '0;
		if (wr_en && (mem_wb.dst == idx))
			return mem_wb.data;
		return regs[idx];
	endfunction

	always_comb begin
		ctrl_d = '0; // Unknown words decode to a no-op
		case (iw.r.op)
			isa_pkg::OP_RTYPE: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.reg_dst   = 1'b1;
				case (iw.r.funct)
					isa_pkg::F_ADD: ctrl_d.alu_op = pipe_pkg::ALU_ADD;
					isa_pkg::F_SUB: ctrl_d.alu_op = pipe_pkg::ALU_SUB;
					isa_pkg::F_AND: ctrl_d.alu_op = pipe_pkg::ALU_AND;
					isa_pkg::F_OR:  ctrl_d.alu_op = pipe_pkg::ALU_OR;
					isa_pkg::F_SLT: ctrl_d.alu_op = pipe_pkg::ALU_SLT;
					default:        ctrl_d = '0; // All-zero word lands here
				endcase
			end
			isa_pkg::OP_ADDI: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.alu_src   = 1'b1;
			end
			isa_pkg::OP_LW: begin
				ctrl_d.reg_write  = 1'b1;
				ctrl_d.mem_to_reg = 1'b1;
				ctrl_d.mem_read   = 1'b1;
				ctrl_d.alu_src    = 1'b1; // Base plus offset
			end
			isa_pkg::OP_SW: begin
				ctrl_d.mem_write = 1'b1;
				ctrl_d.alu_src   = 1'b1;
			end
			isa_pkg::OP_BEQ: begin
				ctrl_d.branch = 1'b1;
				ctrl_d.alu_op = pipe_pkg::ALU_SUB; // Zero flag on equal
			end
			default: ctrl_d = '0;
		endcase
		if (!if_id.valid)
			ctrl_d = '0;
	end

	always_comb begin
		data1_d = read_reg(iw.r.rs);
		data2_d = read_reg(iw.r.rt);
	end

	always_ff @(posedge clk) begin
		if (enable && wr_en) begin
			regs[mem_wb.dst] <= mem_wb.data; // Register file write
		end
	end

	//////////////////////////////
	// ID/EX register

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl  <= '0;
		end else if (enable) begin
			if (flush || stall) begin
				id_ex.valid <= 1'b0; // Bubble
				id_ex.ctrl  <= '0;
			end else begin
				id_ex.valid   <= if_id.valid;
				id_ex.ctrl    <= ctrl_d;
				id_ex.pc_next <= if_id.pc_next;
				id_ex.data1   <= data1_d;
				id_ex.data2   <= data2_d;
				id_ex.imm     <= imm_d;
				id_ex.rs      <= iw.r.rs;
				id_ex.rt      <= iw.r.rt;
				id_ex.dst_r   <= dst_d;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module execute_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               flush,
	input  pipe_pkg::id_ex_t   id_ex,
	input  pipe_pkg::fwd_sel_t fwd_a,
	input  pipe_pkg::fwd_sel_t fwd_b,
	input  pipe_pkg::ex_mem_t  ex_mem_fwd,
	input  pipe_pkg::wb_t      mem_wb,
	output pipe_pkg::ex_mem_t  ex_mem
);

	logic [`CPU_XLEN-1:0] op_a;
	logic [`CPU_XLEN-1:0] rt_val; // Forwarded rt, also store data
	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] alu_y;

	function automatic logic [`CPU_XLEN-1:0] fwd_mux(
		input pipe_pkg::fwd_sel_t   sel,
		input logic [`CPU_XLEN-1:0] reg_val,
		input logic [`CPU_XLEN-1:0] mem_val,
		input logic [`CPU_XLEN-1:0] wb_val
	);
		case (sel)
			pipe_pkg::FWD_MEM: return mem_val;
			pipe_pkg::FWD_WB:  return wb_val;
			default:           return reg_val;
		endcase
	endfunction

	assign op_a   = fwd_mux(fwd_a, id_ex.data1, ex_mem_fwd.alu_result, mem_wb.data);
	assign rt_val = fwd_mux(fwd_b, id_ex.data2, ex_mem_fwd.alu_result, mem_wb.data);
	assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_val;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			pipe_pkg::ALU_ADD: alu_y = op_a + op_b;
			pipe_pkg::ALU_SUB: alu_y = op_a - op_b;
			pipe_pkg::ALU_AND: alu_y = op_a & op_b;
			pipe_pkg::ALU_OR:  alu_y = op_a | op_b;
			pipe_pkg::ALU_SLT: alu_y = {{(`CPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default:           alu_y = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl  <= '0;
		end else if (enable) begin
			if (flush) begin
				ex_mem.valid <= 1'b0; // Younger than the taken beq
				ex_mem.ctrl  <= '0;
			end else begin
				ex_mem.valid      <= id_ex.valid;
				ex_mem.ctrl       <= id_ex.ctrl;
				ex_mem.branch_pc  <= id_ex.pc_next + id_ex.imm[`CPU_PC_W-1:0]; // Word offset
				ex_mem.zero       <= (alu_y == '0);
				ex_mem.alu_result <= alu_y;
				ex_mem.store_data <= rt_val;
				ex_mem.dst        <= id_ex.dst_r;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module mem_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enable,
	input  pipe_pkg::ex_mem_t    ex_mem,
	output pipe_pkg::wb_t        mem_wb,
	output logic                 branch_taken,
	output logic [`CPU_PC_W-1:0] branch_pc,
	output pipe_pkg::dmem_wr_t   dmem_wr
);

	logic [`CPU_XLEN-1:0]    dmem [0:(1<<`CPU_DMEM_AW)-1]; // Data store
	logic [`CPU_DMEM_AW-1:0] daddr;
	logic [`CPU_XLEN-1:0]    load_data;

	assign daddr     = ex_mem.alu_result[`CPU_DMEM_AW+1:2]; // Byte address to word index
	assign load_data = dmem[daddr];                         // Async read

	// Branch resolves here, flushes IF/ID, ID/EX and EX/MEM
	assign branch_taken = ex_mem.valid && ex_mem.ctrl.branch && ex_mem.zero;
	assign branch_pc    = ex_mem.branch_pc;

	assign dmem_wr.en   = enable && ex_mem.valid && ex_mem.ctrl.mem_write; // One per store
	assign dmem_wr.addr = daddr;
	assign dmem_wr.data = ex_mem.store_data;

	always_ff @(posedge clk) begin
		if (dmem_wr.en) begin
			dmem[daddr] <= ex_mem.store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.valid     <= 1'b0;
			mem_wb.reg_write <= 1'b0;
		end else if (enable) begin
			mem_wb.valid     <= ex_mem.valid;
			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.dst       <= ex_mem.dst;
			mem_wb.data      <= ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
		end
	end

endmodule

`default_nettype wire

/* hdl/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module hazard_unit (
	input  pipe_pkg::if_id_t   if_id,
	input  pipe_pkg::id_ex_t   id_ex,
	input  pipe_pkg::ex_mem_t  ex_mem,
	input  pipe_pkg::wb_t      mem_wb,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b,
	output logic               stall
);

	isa_pkg::instr_u iw;      // Instruction waiting in ID
	logic            mem_wr;  // EX/MEM will write a register
	logic            wb_wr;   // MEM/WB will write a register
	logic            load_ex; // Load sitting in EX

	assign iw     = if_id.instr;
	assign mem_wr = ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.dst != '0);
	assign wb_wr  = mem_wb.valid && mem_wb.reg_write && (mem_wb.dst != '0);

	// Nearest producer wins
	function automatic pipe_pkg::fwd_sel_t pick(
		input logic [`CPU_REG_AW-1:0] src,
		input logic                   mem_hit,
		input logic [`CPU_REG_AW-1:0] mem_dst,
		input logic                   wb_hit,
		input logic [`CPU_REG_AW-1:0] wb_dst
	);
		if (mem_hit && (mem_dst == src))
			return pipe_pkg::FWD_MEM;
		if (wb_hit && (wb_dst == src))
			return pipe_pkg::FWD_WB;
		return pipe_pkg::FWD_NONE;
	endfunction

	assign fwd_a = pick(id_ex.rs, mem_wr, ex_mem.dst, wb_wr, mem_wb.dst);
	assign fwd_b = pick(id_ex.rt, mem_wr, ex_mem.dst, wb_wr, mem_wb.dst);

	// Loaded value is not ready for the next instruction
	assign load_ex = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.dst_r != '0);
	assign stall   = if_id.valid && load_ex &&
		((id_ex.dst_r == iw.r.rs) || (id_ex.dst_r == iw.r.rt));

endmodule

`default_nettype wire

/* hdl/pipeline.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module pipeline (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enable,
	input  pipe_pkg::imem_load_t imem_load,
	output pipe_pkg::wb_t        retire,
	output pipe_pkg::dmem_wr_t   dmem_wr
);

	pipe_pkg::if_id_t     if_id;
	pipe_pkg::id_ex_t     id_ex;
	pipe_pkg::ex_mem_t    ex_mem;
	pipe_pkg::wb_t        mem_wb;
	pipe_pkg::fwd_sel_t   fwd_a;
	pipe_pkg::fwd_sel_t   fwd_b;
	logic                 stall;        // Load-use bubble
	logic                 branch_taken; // Also the flush
	logic [`CPU_PC_W-1:0] branch_pc;

	//////////////////////////////
	// Stages

	fetch_stage u_fetch (
		.clk(clk), .rst(rst), .enable(enable), .stall(stall),
		.branch_taken(branch_taken), .branch_pc(branch_pc),
		.imem_load(imem_load), .if_id(if_id)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst), .enable(enable), .stall(stall),
		.flush(branch_taken), .if_id(if_id), .mem_wb(mem_wb), .id_ex(id_ex)
	);

	execute_stage u_execute (
		.clk(clk), .rst(rst), .enable(enable), .flush(branch_taken),
		.id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.ex_mem_fwd(ex_mem), // Own output, read back for forwarding
		.mem_wb(mem_wb), .ex_mem(ex_mem)
	);

	mem_stage u_mem (
		.clk(clk), .rst(rst), .enable(enable), .ex_mem(ex_mem),
		.mem_wb(mem_wb), .branch_taken(branch_taken), .branch_pc(branch_pc),
		.dmem_wr(dmem_wr)
	);

	//////////////////////////////
	// Hazards

	hazard_unit u_hazard (
		.if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
	);

	// Retire flagged only on enabled cycles, MEM/WB holds while disabled
	always_comb begin
		retire       = mem_wb;
		retire.valid = mem_wb.valid && enable;
	end

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_NS    = 10; // 20 ns period
	localparam int RST_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0; // Released on a rising edge
	end

endmodule

`default_nettype wire

/* testbench/cpu_model.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

// One instruction per call, no pipeline timing
module cpu_model #(
	parameter int PROG_LEN = 100
);

	logic [`CPU_XLEN-1:0] imem [0:(1<<`CPU_PC_W)-1];
	logic [`CPU_XLEN-1:0] regs [0:(1<<`CPU_REG_AW)-1];
	logic [`CPU_XLEN-1:0] dmem [0:(1<<`CPU_DMEM_AW)-1];
	int                   pc; // Word index, never wraps here

	task automatic load_word(input int addr, input logic [`CPU_XLEN-1:0] word);
		imem[addr] = word;
	endtask

	task automatic reset_state();
		pc = 0;
		for (int i = 0; i < (1<<`CPU_REG_AW); i++)
			regs[i] = '0;
		for (int i = 0; i < (1<<`CPU_DMEM_AW); i++)
			dmem[i] = '0;
	endtask

	task automatic step(
		output logic               done,
		output pipe_pkg::wb_t      wr,
		output pipe_pkg::dmem_wr_t st
	);
		isa_pkg::instr_u      iw;
		logic [`CPU_XLEN-1:0] a;
		logic [`CPU_XLEN-1:0] b;
		logic [`CPU_XLEN-1:0] simm;
		logic [`CPU_XLEN-1:0] addr;
		wr   = '0;
		st   = '0;
		done = (pc >= PROG_LEN); // Ran into the no-op area
		if (!done) begin
			iw   = imem[pc];
			a    = regs[iw.r.rs];
			b    = regs[iw.r.rt];
			simm = {{(`CPU_XLEN-16){iw.i.imm16[15]}}, iw.i.imm16};
			addr = a + simm; // Byte address for lw and sw
			pc   = pc + 1;
			case (iw.r.op)
				isa_pkg::OP_RTYPE: begin
					wr.reg_write = 1'b1;
					wr.dst       = iw.r.rd;
					case (iw.r.funct)
						isa_pkg::F_ADD: wr.data = a + b;
						isa_pkg::F_SUB: wr.data = a - b;
						isa_pkg::F_AND: wr.data = a & b;
						isa_pkg::F_OR:  wr.data = a | b;
						isa_pkg::F_SLT: wr.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:        wr.reg_write = 1'b0; // Zero word is a no-op
					endcase
				end
				isa_pkg::OP_ADDI: begin
					wr.reg_write = 1'b1;
					wr.dst       = iw.i.rt;
					wr.data      = a + simm;
				end
				isa_pkg::OP_LW: begin
					wr.reg_write = 1'b1;
					wr.dst       = iw.i.rt;
					wr.data      = dmem[addr[`CPU_DMEM_AW+1:2]];
				end
				isa_pkg::OP_SW: begin
					st.en   = 1'b1;
					st.addr = addr[`CPU_DMEM_AW+1:2];
					st.data = b;
					dmem[addr[`CPU_DMEM_AW+1:2]] = b;
				end
				isa_pkg::OP_BEQ: begin
					if (a == b)
						pc = pc + int'($signed(simm)); // Relative to the next word
				end
				default: ;
			endcase
			if (wr.reg_write && (wr.dst != '0)) begin
				regs[wr.dst] = wr.data;
				wr.valid     = 1'b1;
			end else begin
				wr = '0; // r0 writes are not architectural
			end
		end
	endtask

endmodule

`default_nettype wire

/* testbench/pipeline_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module pipeline_tb;

	localparam int PROG_LEN   = 100;
	localparam int IMEM_WORDS = 1 << `CPU_PC_W;
	localparam int PC_W       = `CPU_PC_W;
	localparam int RUN_LIMIT  = IMEM_WORDS * 3 + 200; // Cycles once the run starts

	logic                 clk;
	logic                 rst;
	logic                 enable = 1'b0;
	pipe_pkg::imem_load_t imem_load;
	pipe_pkg::wb_t        retire;
	pipe_pkg::dmem_wr_t   dmem_wr;

	integer               seed = 32'h3a7a_79dc;
	logic [`CPU_XLEN-1:0] prog [0:IMEM_WORDS-1];
	logic [15:0]          known [$];    // Store offsets no beq can skip
	pipe_pkg::wb_t        exp_regs [$];
	pipe_pkg::dmem_wr_t   exp_stores [$];
	logic                 running = 1'b0;
	int                   cycles;

	clock_gen clkgen (.clk(clk), .rst(rst));

	pipeline uut (
		.clk(clk), .rst(rst), .enable(enable), .imem_load(imem_load),
		.retire(retire), .dmem_wr(dmem_wr)
	);

	cpu_model #(.PROG_LEN(PROG_LEN)) model ();

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	function automatic logic [4:0] any_reg();
		return 5'(rand_below(8)); // r0 to r7
	endfunction

	function automatic isa_pkg::funct_t pick_funct();
		case (rand_below(5))
			0:       return isa_pkg::F_ADD;
			1:       return isa_pkg::F_SUB;
			2:       return isa_pkg::F_AND;
			3:       return isa_pkg::F_OR;
			default: return isa_pkg::F_SLT;
		endcase
	endfunction

	function automatic logic [31:0] make_r(input isa_pkg::funct_t f,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
		isa_pkg::instr_u w;
		w.r.op    = isa_pkg::OP_RTYPE;
		w.r.rs    = rs;
		w.r.rt    = rt;
		w.r.rd    = rd;
		w.r.shamt = 5'd0;
		w.r.funct = f;
		return w;
	endfunction

	function automatic logic [31:0] make_i(input isa_pkg::opcode_t op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		isa_pkg::instr_u w;
		w.i.op    = op;
		w.i.rs    = rs;
		w.i.rt    = rt;
		w.i.imm16 = imm;
		return w;
	endfunction

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	//////////////////////////////
	// Program and expected events

	task automatic build_program();
		int          kind;
		int          shadow_end;
		logic [4:0]  ra;
		logic [15:0] off;
		shadow_end = -1;
		for (int i = 0; i < IMEM_WORDS; i++)
			prog[i] = '0;
		for (int i = 0; i < 7; i++)
			prog[i] = make_i(isa_pkg::OP_ADDI, 5'd0, 5'(i + 1), 16'(rand_below(65536)));
		for (int i = 7; i < PROG_LEN; i++) begin
			kind = rand_below(10);
			ra   = any_reg();
			if (kind >= 5 && kind <= 6 && known.size() == 0)
				kind = 7; // No defined word to load yet
			if (kind <= 3) begin
				prog[i] = make_r(pick_funct(), ra, any_reg(), any_reg());
			end else if (kind == 4) begin
				prog[i] = make_i(isa_pkg::OP_ADDI, ra, any_reg(), 16'(rand_below(65536)));
			end else if (kind <= 6) begin
				off     = known[rand_below(known.size())];
				prog[i] = make_i(isa_pkg::OP_LW, 5'd0, ra, off);
			end else if (kind <= 8) begin
				off     = 16'(rand_below(64) * 4);
				prog[i] = make_i(isa_pkg::OP_SW, 5'd0, ra, off);
				if (i > shadow_end)
					known.push_back(off);
			end else begin
				off     = 16'(rand_below(4) + 1); // Forward only
				prog[i] = make_i(isa_pkg::OP_BEQ, ra,
					(rand_below(2) == 0) ? ra : any_reg(), off);
				if (i + int'(off) > shadow_end)
					shadow_end = i + int'(off);
			end
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			@(posedge clk);
			imem_load <= '{we: 1'b1, addr: PC_W'(i), data: prog[i]};
			model.load_word(i, prog[i]);
		end
		@(posedge clk);
		imem_load <= '0;
	endtask

	task automatic run_model();
		logic               done;
		pipe_pkg::wb_t      wr;
		pipe_pkg::dmem_wr_t st;
		model.reset_state();
		done = 1'b0;
		while (!done) begin
			model.step(done, wr, st);
			if (wr.valid)
				exp_regs.push_back(wr);
			if (st.en)
				exp_stores.push_back(st);
		end
	endtask

	always @(posedge clk) begin
		if (!running)
			enable <= 1'b0;
		else if (!enable)
			enable <= 1'b1; // Drops last one cycle
		else
			enable <= (rand_below(8) != 0);
	end

	//////////////////////////////
	// Run and compare

	initial begin
		pipe_pkg::wb_t      want_wb;
		pipe_pkg::dmem_wr_t want_st;
		logic               finished;
		imem_load = '0;
		cycles    = 0;
		finished  = 1'b0;
		build_program();
		load_program(); // Overlaps reset, enable stays low
		run_model();
		@(posedge clk);
		running <= 1'b1;
		while (!finished) begin
			@(negedge clk); // Outputs settled mid-cycle
			if (retire.valid && retire.reg_write && (retire.dst != '0)) begin
				assert (exp_regs.size() > 0) else
					stop_with_error("A register write retired that the model never made");
				want_wb = exp_regs.pop_front();
				check_value("retire", 64'({want_wb.dst, want_wb.data}),
					64'({retire.dst, retire.data}));
			end
			if (dmem_wr.en) begin
				assert (exp_stores.size() > 0) else
					stop_with_error("A store reached data memory that the model never made");
				want_st = exp_stores.pop_front();
				check_value("store", 64'({want_st.addr, want_st.data}),
					64'({dmem_wr.addr, dmem_wr.data}));
			end
			cycles++;
			assert (cycles <= RUN_LIMIT) else
				stop_with_error("Timeout, the program did not finish within the cycle limit");
			finished = (exp_regs.size() == 0) && (exp_stores.size() == 0) &&
				(int'(uut.u_fetch.pc) >= PROG_LEN);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/hazard_unit.sv
hdl/pipeline.sv
testbench/clock_gen.sv
testbench/cpu_model.sv
testbench/pipeline_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module pipeline_tb -f sim.f > /dev/null &&
./obj_dir/Vpipeline_tb | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }
